//--- mulArithPkg.sv
package mulArithPkg;

    localparam int opWidth   = 8;
    localparam int prodWidth = 2 * opWidth;
    localparam int pipeDepth = 3;
    // Eight AND rows plus the correction-constant row
    localparam int ppRows    = opWidth + 1;
    localparam int claGroup  = 4;

    typedef logic signed [opWidth-1:0]   operand_t;
    typedef logic signed [prodWidth-1:0] product_t;
    typedef logic [prodWidth-1:0]        ppRow_t;
    typedef ppRow_t [ppRows-1:0]         ppMatrix_t;

    typedef struct packed {
        ppRow_t sum;
        ppRow_t carry;
    } sumPair_t;

    typedef struct packed {
        logic carry;
        logic sum;
    } faBits_t;

    function automatic faBits_t fullAdd(input logic a, input logic b, input logic c);
        faBits_t r;
        r.sum   = a ^ b ^ c;
        r.carry = (a & b) | (a & c) | (b & c);
        return r;
    endfunction

endpackage

//--- mulBusPkg.sv
package mulBusPkg;

    localparam int addrWidth     = 4;
    localparam int dataWidth     = 32;
    localparam int statusBusyBit = 0;
    localparam int statusDoneBit = 1;
    localparam int ctrlStartBit  = 0;

    typedef enum logic [1:0] {
        respOkay   = 2'b00,
        respSlvErr = 2'b10
    } axiResp_e;

    typedef enum logic [addrWidth-1:0] {
        regOperands = 4'h0,
        regCtrl     = 4'h4,
        regStatus   = 4'h8,
        regResult   = 4'hC
    } regAddr_e;

    typedef struct packed {
        logic [addrWidth-1:0] awaddr;
        logic                 awvalid;
        logic [dataWidth-1:0] wdata;
        logic                 wvalid;
        logic                 bready;
        logic [addrWidth-1:0] araddr;
        logic                 arvalid;
        logic                 rready;
    } axiReq_t;

    typedef struct packed {
        logic                 awready;
        logic                 wready;
        axiResp_e             bresp;
        logic                 bvalid;
        logic [dataWidth-1:0] rdata;
        axiResp_e             rresp;
        logic                 rvalid;
        logic                 arready;
    } axiRsp_t;

endpackage

//--- partialProductGen.sv
`timescale 1ns/1ns

module partialProductGen (
    input  logic                   clk,
    input  logic                   arstN,
    input  mulArithPkg::operand_t  opA,
    input  mulArithPkg::operand_t  opB,
    input  logic                   inValid,
    output mulArithPkg::ppMatrix_t ppOut,
    output logic                   outValid
);
    import mulArithPkg::*;

    ppMatrix_t ppNext;

    // Baugh-Wooley rows, a term pairing exactly one sign bit is inverted
    always_comb begin
        ppNext = '0;
        for (int i = 0; i < opWidth; i++) begin
            for (int j = 0; j < opWidth; j++) begin
                ppNext[i][i+j] = (opA[j] & opB[i]) ^
                                 ((i == opWidth - 1) != (j == opWidth - 1));
            end
        end
        // Correction ones that fold the inverted terms back to two's complement
        ppNext[opWidth][opWidth]       = 1'b1;
        ppNext[opWidth][prodWidth - 1] = 1'b1;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            ppOut <= ppNext;
        end
    end

endmodule

//--- carrySaveTree.sv
`timescale 1ns/1ns

module carrySaveTree (
    input  logic                   clk,
    input  logic                   arstN,
    input  mulArithPkg::ppMatrix_t ppIn,
    input  logic                   inValid,
    output mulArithPkg::sumPair_t  rowsOut,
    output logic                   outValid
);
    import mulArithPkg::*;

    sumPair_t l1a;
    sumPair_t l1b;
    sumPair_t l1c;
    sumPair_t l2a;
    sumPair_t l2b;
    sumPair_t l3;
    sumPair_t l4;

    // One row of 3:2 compressors, carries move up one column
    function automatic sumPair_t compress(input ppRow_t a, input ppRow_t b, input ppRow_t c);
        faBits_t  fa;
        sumPair_t r;
        r = '0;
        for (int k = 0; k < prodWidth; k++) begin
            fa         = fullAdd(a[k], b[k], c[k]);
            r.sum[k]   = fa.sum;
            if (k < prodWidth - 1) begin
                r.carry[k+1] = fa.carry;
            end
        end
        return r;
    endfunction

    // Nine rows down to six
    assign l1a = compress(ppIn[0], ppIn[1], ppIn[2]);
    assign l1b = compress(ppIn[3], ppIn[4], ppIn[5]);
    assign l1c = compress(ppIn[6], ppIn[7], ppIn[8]);

    // Six down to four
    assign l2a = compress(l1a.sum, l1a.carry, l1b.sum);
    assign l2b = compress(l1b.carry, l1c.sum, l1c.carry);

    // Four down to three, l2b.carry waits one layer
    assign l3 = compress(l2a.sum, l2a.carry, l2b.sum);

    assign l4 = compress(l3.sum, l3.carry, l2b.carry);

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            rowsOut <= l4;
        end
    end

endmodule

//--- lookaheadAdder.sv
`timescale 1ns/1ns

module lookaheadAdder (
    input  logic                  clk,
    input  logic                  arstN,
    input  mulArithPkg::sumPair_t rowsIn,
    input  logic                  inValid,
    output mulArithPkg::product_t prodOut,
    output logic                  outValid
);
    import mulArithPkg::*;

    logic [prodWidth-1:0] prop;
    logic [prodWidth-1:0] gen;
    logic [prodWidth-1:0] carry;

    function automatic logic [claGroup-1:0] groupCarries(input logic [claGroup-1:0] g,
                                                         input logic [claGroup-1:0] p,
                                                         input logic cin);
        logic [claGroup-1:0] c;
        c[0] = g[0] | (p[0] & cin);
        c[1] = g[1] | (p[1] & g[0]) | (p[1] & p[0] & cin);
        c[2] = g[2] | (p[2] & g[1]) | (p[2] & p[1] & g[0]) | (p[2] & p[1] & p[0] & cin);
        c[3] = g[3] | (p[3] & g[2]) | (p[3] & p[2] & g[1]) | (p[3] & p[2] & p[1] & g[0])
             | (&p & cin);
        return c;
    endfunction

    // Half add per column gives propagate and generate
    always_comb begin : pgBits
        faBits_t pg;
        for (int k = 0; k < prodWidth; k++) begin
            pg      = fullAdd(rowsIn.sum[k], rowsIn.carry[k], 1'b0);
            prop[k] = pg.sum;
            gen[k]  = pg.carry;
        end
    end

    // Groups chained through their carry out; the top group's carry out is dropped
    always_comb begin : carryChain
        logic [claGroup-1:0] grp;
        carry[0] = 1'b0;
        for (int k = 0; k < prodWidth / claGroup; k++) begin
            grp = groupCarries(gen[claGroup*k +: claGroup], prop[claGroup*k +: claGroup],
                               carry[claGroup*k]);
            carry[claGroup*k+1 +: claGroup-1] = grp[claGroup-2:0];
            if (k < prodWidth / claGroup - 1) begin
                carry[claGroup*(k+1)] = grp[claGroup-1];
            end
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    always_ff @(posedge clk) begin
        if (inValid) begin
            prodOut <= product_t'(prop ^ carry);
        end
    end

    sumMatches: assert property (@(posedge clk) disable iff (!arstN)
        outValid |-> prodOut == product_t'($past(rowsIn.sum) + $past(rowsIn.carry)));

endmodule

//--- mulCtrl.sv
`timescale 1ns/1ns

module mulCtrl (
    input  logic                  clk,
    input  logic                  arstN,
    input  mulBusPkg::axiReq_t    busReq,
    output mulBusPkg::axiRsp_t    busRsp,
    output mulArithPkg::operand_t opA,
    output mulArithPkg::operand_t opB,
    output logic                  launch,
    input  mulArithPkg::product_t prodIn,
    input  logic                  prodValid
);
    import mulArithPkg::*;
    import mulBusPkg::*;

    typedef enum logic {
        ctrlIdle,
        ctrlBusy
    } ctrlState_e;

    ctrlState_e           state;
    logic                 startReq;
    logic                 doneQ;
    product_t             resultQ;
    regAddr_e             wrAddr;
    regAddr_e             rdAddr;
    logic                 wrFire;
    logic                 arFire;
    logic                 startWrite;
    logic                 refuse;
    logic                 stateBusy;
    logic                 doneFlag;
    product_t             resultView;
    axiResp_e             wrResp;
    axiResp_e             rdResp;
    logic [dataWidth-1:0] rdNext;
    logic                 bvalid;
    axiResp_e             bresp;
    logic                 rvalid;
    logic [dataWidth-1:0] rdata;
    axiResp_e             rresp;

    // Address and data are taken on the same edge, one write response outstanding
    assign wrFire = busReq.awvalid && busReq.wvalid && !bvalid;
    assign arFire = busReq.arvalid && !rvalid;
    assign wrAddr = regAddr_e'(busReq.awaddr);
    assign rdAddr = regAddr_e'(busReq.araddr);

    // A product arriving from the adder is visible in status on that same edge
    assign stateBusy  = (state == ctrlBusy) && !prodValid;
    assign doneFlag   = doneQ || prodValid;
    assign resultView = prodValid ? prodIn : resultQ;
    assign refuse     = stateBusy || startReq;
    assign startWrite = wrFire && (wrAddr == regCtrl) && busReq.wdata[ctrlStartBit];

    always_comb begin
        case (wrAddr)
            regOperands: wrResp = respOkay;
            regCtrl:     wrResp = (busReq.wdata[ctrlStartBit] && refuse) ? respSlvErr : respOkay;
            default:     wrResp = respSlvErr;
        endcase
    end

    always_comb begin
        rdNext = '0;
        rdResp = respOkay;
        case (rdAddr)
            regOperands: rdNext = {{(dataWidth - 2 * opWidth){1'b0}}, opB, opA};
            regCtrl:     rdNext[ctrlStartBit] = startReq;
            regStatus: begin
                rdNext[statusBusyBit] = stateBusy;
                rdNext[statusDoneBit] = doneFlag;
            end
            regResult:   rdNext = {{(dataWidth - prodWidth){resultView[prodWidth-1]}}, resultView};
            default:     rdResp = respSlvErr;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            opA <= '0;
            opB <= '0;
        end else if (wrFire && wrAddr == regOperands) begin
            {opB, opA} <= busReq.wdata[2*opWidth-1:0];
        end
    end

    // Launch trails the accepted start by one cycle, together with busy
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state    <= ctrlIdle;
            startReq <= 1'b0;
            launch   <= 1'b0;
            doneQ    <= 1'b0;
            resultQ  <= '0;
        end else begin
            startReq <= startWrite && !refuse;
            launch   <= startReq;
            case (state)
                ctrlIdle: begin
                    if (startReq) begin
                        state <= ctrlBusy;
                        doneQ <= 1'b0;
                    end
                end
                ctrlBusy: begin
                    if (prodValid) begin
                        state   <= ctrlIdle;
                        doneQ   <= 1'b1;
                        resultQ <= prodIn;
                    end
                end
                default: state <= ctrlIdle;
            endcase
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            bvalid <= 1'b0;
            bresp  <= respOkay;
            rvalid <= 1'b0;
            rdata  <= '0;
            rresp  <= respOkay;
        end else begin
            if (wrFire) begin
                bvalid <= 1'b1;
                bresp  <= wrResp;
            end else if (busReq.bready) begin
                bvalid <= 1'b0;
            end
            if (arFire) begin
                rvalid <= 1'b1;
                rdata  <= rdNext;
                rresp  <= rdResp;
            end else if (busReq.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_comb begin
        busRsp.awready = wrFire;
        busRsp.wready  = wrFire;
        busRsp.bresp   = bresp;
        busRsp.bvalid  = bvalid;
        busRsp.rdata   = rdata;
        busRsp.rresp   = rresp;
        busRsp.rvalid  = rvalid;
        busRsp.arready = arFire;
    end

    bHold: assert property (@(posedge clk) disable iff (!arstN)
        bvalid && !busReq.bready |=> bvalid && $stable(bresp));

    rHold: assert property (@(posedge clk) disable iff (!arstN)
        rvalid && !busReq.rready |=> rvalid && $stable(rdata) && $stable(rresp));

    prodInBusy: assert property (@(posedge clk) disable iff (!arstN)
        prodValid |-> state == ctrlBusy);

    // Datapath latency seen from the controller
    prodLatency: assert property (@(posedge clk) disable iff (!arstN)
        launch |-> ##pipeDepth prodValid);

endmodule

//--- mulTop.sv
`timescale 1ns/1ns

module mulTop (
    input  logic               clk,
    input  logic               arstN,
    input  mulBusPkg::axiReq_t busReq,
    output mulBusPkg::axiRsp_t busRsp
);
    import mulArithPkg::*;

    operand_t  opA;
    operand_t  opB;
    logic      launch;
    ppMatrix_t ppMatrix;
    logic      ppValid;
    sumPair_t  rows;
    logic      rowsValid;
    product_t  product;
    logic      prodValid;

    mulCtrl u_ctrl (
        .clk      (clk),
        .arstN    (arstN),
        .busReq   (busReq),
        .busRsp   (busRsp),
        .opA      (opA),
        .opB      (opB),
        .launch   (launch),
        .prodIn   (product),
        .prodValid(prodValid)
    );

    partialProductGen u_ppGen (
        .clk     (clk),
        .arstN   (arstN),
        .opA     (opA),
        .opB     (opB),
        .inValid (launch),
        .ppOut   (ppMatrix),
        .outValid(ppValid)
    );

    carrySaveTree u_tree (
        .clk     (clk),
        .arstN   (arstN),
        .ppIn    (ppMatrix),
        .inValid (ppValid),
        .rowsOut (rows),
        .outValid(rowsValid)
    );

    lookaheadAdder u_adder (
        .clk     (clk),
        .arstN   (arstN),
        .rowsIn  (rows),
        .inValid (rowsValid),
        .prodOut (product),
        .outValid(prodValid)
    );

endmodule

//--- tbMul.sv
`timescale 1ns/1ns

module tbMul;
    import mulArithPkg::*;
    import mulBusPkg::*;

    // Up to 60 multiplications of about 30 bus cycles each, plus margin
    localparam int mulRuns    = 60;
    localparam int mulCycles  = 30;
    localparam int cycleLimit = mulRuns * mulCycles + 1200;

    logic        clk;
    logic        arstN;
    axiReq_t     busReq;
    axiRsp_t     busRsp;
    int          errorCount;
    int          testCount;
    int          cycleCount;
    logic [31:0] rngState;

    mulTop dut0 (
        .clk   (clk),
        .arstN (arstN),
        .busReq(busReq),
        .busRsp(busRsp)
    );

    always #5 clk = ~clk;

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        errorCount++;
        $display("CHECK FAILED %s: expected 0x%08h, got 0x%08h", name, expected, actual);
    endtask

    function automatic logic [31:0] nextRandom();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    // Signed product sign-extended to the 32-bit register width
    function automatic logic [31:0] refProduct(input operand_t a, input operand_t b);
        int prod;
        prod = int'(a) * int'(b);
        return prod;
    endfunction

    task automatic axiWrite(input logic [3:0] addr, input logic [31:0] data, input int stall,
                            output axiResp_e resp);
        @(posedge clk);
        busReq.awaddr  <= addr;
        busReq.awvalid <= 1'b1;
        busReq.wdata   <= data;
        busReq.wvalid  <= 1'b1;
        busReq.bready  <= (stall == 0);
        do @(negedge clk); while (!busRsp.awready);
        if (busRsp.wready !== 1'b1) reportMismatch("wready", 32'h1, busRsp.wready);
        @(posedge clk);
        busReq.awvalid <= 1'b0;
        busReq.wvalid  <= 1'b0;
        do @(negedge clk); while (!busRsp.bvalid);
        resp = busRsp.bresp;
        // Response must hold while bready stays low
        repeat (stall) begin
            @(negedge clk);
            if (busRsp.bvalid !== 1'b1) reportMismatch("bvalid", 32'h1, busRsp.bvalid);
            if (busRsp.bresp !== resp) reportMismatch("bresp", resp, busRsp.bresp);
        end
        if (stall > 0) begin
            @(posedge clk);
            busReq.bready <= 1'b1;
        end
        @(posedge clk);
        busReq.bready <= 1'b0;
        @(negedge clk);
        if (busRsp.bvalid !== 1'b0) reportMismatch("bvalid", 32'h0, busRsp.bvalid);
    endtask

    task automatic axiRead(input logic [3:0] addr, input int stall,
                           output logic [31:0] data, output axiResp_e resp);
        @(posedge clk);
        busReq.araddr  <= addr;
        busReq.arvalid <= 1'b1;
        busReq.rready  <= (stall == 0);
        do @(negedge clk); while (!busRsp.arready);
        @(posedge clk);
        busReq.arvalid <= 1'b0;
        do @(negedge clk); while (!busRsp.rvalid);
        data = busRsp.rdata;
        resp = busRsp.rresp;
        repeat (stall) begin
            @(negedge clk);
            if (busRsp.rvalid !== 1'b1) reportMismatch("rvalid", 32'h1, busRsp.rvalid);
            if (busRsp.rdata !== data) reportMismatch("rdata", data, busRsp.rdata);
            if (busRsp.rresp !== resp) reportMismatch("rresp", resp, busRsp.rresp);
        end
        if (stall > 0) begin
            @(posedge clk);
            busReq.rready <= 1'b1;
        end
        @(posedge clk);
        busReq.rready <= 1'b0;
        @(negedge clk);
        if (busRsp.rvalid !== 1'b0) reportMismatch("rvalid", 32'h0, busRsp.rvalid);
    endtask

    task automatic runMul(input operand_t a, input operand_t b, output logic [31:0] result);
        axiResp_e    resp;
        logic [31:0] status;
        axiWrite(regOperands, {16'h0, b, a}, 0, resp);
        if (resp !== respOkay) reportMismatch("bresp", respOkay, resp);
        axiWrite(regCtrl, 32'h1, 0, resp);
        if (resp !== respOkay) reportMismatch("bresp", respOkay, resp);
        do axiRead(regStatus, 0, status, resp); while (!status[statusDoneBit]);
        axiRead(regResult, 0, result, resp);
        if (resp !== respOkay) reportMismatch("rresp", respOkay, resp);
    endtask

    task automatic checkProduct(input operand_t a, input operand_t b);
        logic [31:0] result;
        logic [31:0] expected;
        runMul(a, b, result);
        expected = refProduct(a, b);
        if (result !== expected) begin
            reportMismatch($sformatf("regResult for %0d * %0d", a, b), expected, result);
        end
    endtask

    task automatic finishTest(input string name, input int errorsBefore);
        testCount++;
        $display("%s: finished with %0d errors", name, errorCount - errorsBefore);
    endtask

    task automatic cornerProducts();
        int startErrors;
        startErrors = errorCount;
        checkProduct(0, 0);
        checkProduct(-1, -1);
        checkProduct(-128, -128);
        checkProduct(-128, 127);
        checkProduct(127, 127);
        checkProduct(1, -128);
        finishTest("corner products", startErrors);
    endtask

    task automatic randomProducts();
        int          startErrors;
        logic [31:0] r;
        startErrors = errorCount;
        repeat (40) begin
            r = nextRandom();
            checkProduct(r[7:0], r[15:8]);
        end
        finishTest("random products", startErrors);
    endtask

    task automatic registerMap();
        int          startErrors;
        logic [31:0] data;
        axiResp_e    resp;
        startErrors = errorCount;
        checkProduct(-3, 7);
        axiRead(regStatus, 0, data, resp);
        if (data[statusDoneBit] !== 1'b1) reportMismatch("status done", 32'h1, data[1]);
        if (data[statusBusyBit] !== 1'b0) reportMismatch("status busy", 32'h0, data[0]);
        axiWrite(regOperands, 32'h1234_A5C3, 0, resp);
        if (resp !== respOkay) reportMismatch("bresp", respOkay, resp);
        axiRead(regOperands, 0, data, resp);
        if (data[15:0] !== 16'hA5C3) reportMismatch("regOperands", 32'hA5C3, data[15:0]);
        finishTest("register map", startErrors);
    endtask

    task automatic errorResponses();
        int          startErrors;
        logic [31:0] data;
        axiResp_e    resp;
        startErrors = errorCount;
        checkProduct(13, -9);
        axiWrite(regResult, 32'h0000_5555, 0, resp);
        if (resp !== respSlvErr) reportMismatch("bresp", respSlvErr, resp);
        // Status address plus one is unmapped
        axiRead(4'h9, 0, data, resp);
        if (resp !== respSlvErr) reportMismatch("rresp", respSlvErr, resp);
        if (data !== 32'h0) reportMismatch("rdata", 32'h0, data);
        // B = -9 in bits 15:8, A = 13 in bits 7:0
        axiRead(regOperands, 0, data, resp);
        if (data !== 32'h0000_F70D) reportMismatch("regOperands", 32'h0000_F70D, data);
        axiRead(regResult, 0, data, resp);
        if (data !== refProduct(13, -9)) reportMismatch("regResult", refProduct(13, -9), data);
        finishTest("error responses", startErrors);
    endtask

    task automatic backPressure();
        int          startErrors;
        logic [31:0] data;
        axiResp_e    resp;
        startErrors = errorCount;
        axiWrite(regOperands, 32'h0000_3C5A, 5, resp);
        if (resp !== respOkay) reportMismatch("bresp", respOkay, resp);
        axiRead(regOperands, 5, data, resp);
        if (resp !== respOkay) reportMismatch("rresp", respOkay, resp);
        if (data !== 32'h0000_3C5A) reportMismatch("regOperands", 32'h0000_3C5A, data);
        finishTest("back-pressure", startErrors);
    endtask

    task automatic startWhileBusy();
        int          startErrors;
        logic [31:0] data;
        axiResp_e    resp;
        operand_t    a;
        operand_t    b;
        startErrors = errorCount;
        a = -77;
        b = 45;
        axiWrite(regOperands, {16'h0, b, a}, 0, resp);
        axiWrite(regCtrl, 32'h1, 0, resp);
        if (resp !== respOkay) reportMismatch("bresp", respOkay, resp);
        axiWrite(regCtrl, 32'h1, 0, resp);
        if (resp !== respSlvErr) reportMismatch("bresp", respSlvErr, resp);
        do axiRead(regStatus, 0, data, resp); while (!data[statusDoneBit]);
        axiRead(regResult, 0, data, resp);
        if (data !== refProduct(a, b)) reportMismatch("regResult", refProduct(a, b), data);
        finishTest("start while busy", startErrors);
    endtask

    initial begin
        clk        = 1'b0;
        arstN      = 1'b0;
        busReq     = '0;
        errorCount = 0;
        testCount  = 0;
        rngState   = 32'd58;
        repeat (2) @(posedge clk);
        arstN <= 1'b1;
        cornerProducts();
        randomProducts();
        registerMap();
        errorResponses();
        backPressure();
        startWhileBusy();
        $display("%0d tests run, %0d errors", testCount, errorCount);
        if (errorCount == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

    initial begin
        cycleCount = 0;
        while (cycleCount < cycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Run stopped after %0d cycles before the tests finished", cycleLimit);
        $display("TESTS FAILED");
        $finish;
    end

endmodule

//--- files.f
mulArithPkg.sv
mulBusPkg.sv
partialProductGen.sv
carrySaveTree.sv
lookaheadAdder.sv
mulCtrl.sv
mulTop.sv
tbMul.sv

//--- Bender.yml
package:
  name: mul_axi

sources:
  - mulArithPkg.sv
  - mulBusPkg.sv
  - partialProductGen.sv
  - carrySaveTree.sv
  - lookaheadAdder.sv
  - mulCtrl.sv
  - mulTop.sv
  - target: test
    files:
      - tbMul.sv
